// ==== hw/dispatch_buffer.sv ====
`timescale 1ns/1ns

module dispatch_buffer (
	input logic clk,
	input logic rst,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input dispatch_pkg::instr_word_t wb_dat_i,
	output dispatch_pkg::instr_word_t wb_dat_o,
	output logic wb_ack_o,
	output logic ret_valid_o,
	output dispatch_pkg::tag_t ret_tag_o,
	output dispatch_pkg::result_t ret_result_o,
	issue_if.mon iss,
	writeback_if.dst wb
);

	// ============================================================
	// entry storage
	// ============================================================

	// control flags
	logic [dispatch_pkg::DBF_ENTRIES-1:0] ent_valid;
	logic [dispatch_pkg::DBF_ENTRIES-1:0] ent_out;
	logic [dispatch_pkg::DBF_ENTRIES-1:0] ent_done;
	// payload
	logic [dispatch_pkg::DBF_ENTRIES-1:0] ent_pred;
	dispatch_pkg::op_class_e ent_cls [dispatch_pkg::DBF_ENTRIES];
	dispatch_pkg::tag_t ent_tag [dispatch_pkg::DBF_ENTRIES];
	dispatch_pkg::operand_t ent_opa [dispatch_pkg::DBF_ENTRIES];
	dispatch_pkg::operand_t ent_opb [dispatch_pkg::DBF_ENTRIES];
	dispatch_pkg::result_t ent_res [dispatch_pkg::DBF_ENTRIES];

	// circular pointers
	dispatch_pkg::buf_ndx_t head;
	dispatch_pkg::buf_ndx_t tail;
	dispatch_pkg::buf_cnt_t count;
	dispatch_pkg::buf_cnt_t free_cnt;

	logic full;
	logic wr_acc;
	logic rd_acc;
	logic do_ret;
	dispatch_pkg::op_class_e wr_cls;

	assign full = count == dispatch_pkg::buf_cnt_t'(dispatch_pkg::DBF_ENTRIES);
	assign free_cnt = dispatch_pkg::buf_cnt_t'(dispatch_pkg::DBF_ENTRIES) - count;

	// no new request in the ack cycle, the master drops stb there
	assign wr_acc = wb_cyc_i && wb_stb_i && wb_we_i && !full && !wb_ack_o;
	assign rd_acc = wb_cyc_i && wb_stb_i && !wb_we_i && !wb_ack_o;

	// head leaves once its result is in
	assign do_ret = ent_valid[head] && ent_done[head];

	assign wr_cls = dispatch_pkg::op_class_e'(wb_dat_i[dispatch_pkg::CLS_HI:dispatch_pkg::CLS_LO]);

	// ============================================================
	// control state
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			ent_valid <= '0;
			ent_out <= '0;
			ent_done <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
			wb_ack_o <= 1'b0;
			ret_valid_o <= 1'b0;
		end else begin
			wb_ack_o <= wr_acc || rd_acc;
			ret_valid_o <= do_ret;
			// issue seen this cycle, flag lands next cycle
			for (int u = 0; u < dispatch_pkg::NUM_UNITS; u++) begin
				if (iss.valid[u])
					ent_out[iss.ndx[u]] <= 1'b1;
			end
			// lanes never share an index
			for (int u = 0; u < dispatch_pkg::NUM_UNITS; u++) begin
				if (wb.valid[u])
					ent_done[wb.ndx[u]] <= 1'b1;
			end
			if (do_ret) begin
				ent_valid[head] <= 1'b0;
				head <= head + 1'b1;
			end
			// tail never equals a valid head while not full
			if (wr_acc) begin
				ent_valid[tail] <= 1'b1;
				ent_out[tail] <= 1'b0;
				// nops skip execution entirely
				ent_done[tail] <= wr_cls == dispatch_pkg::CLS_NOP;
				tail <= tail + 1'b1;
			end
			count <= count + dispatch_pkg::buf_cnt_t'(wr_acc) - dispatch_pkg::buf_cnt_t'(do_ret);
		end
	end

	// ============================================================
	// payload and port data
	// ============================================================

	always_ff @(posedge clk) begin
		for (int u = 0; u < dispatch_pkg::NUM_UNITS; u++) begin
			if (wb.valid[u])
				ent_res[wb.ndx[u]] <= wb.res[u];
		end
		if (wr_acc) begin
			ent_cls[tail] <= wr_cls;
			ent_pred[tail] <= wb_dat_i[dispatch_pkg::PRED_BIT];
			ent_tag[tail] <= wb_dat_i[dispatch_pkg::TAG_HI:dispatch_pkg::TAG_LO];
			ent_opa[tail] <= wb_dat_i[dispatch_pkg::OPA_HI:dispatch_pkg::OPA_LO];
			ent_opb[tail] <= wb_dat_i[dispatch_pkg::OPB_HI:dispatch_pkg::OPB_LO];
			// zero stays for nops, others get overwritten at writeback
			ent_res[tail] <= '0;
		end
		if (do_ret) begin
			ret_tag_o <= ent_tag[head];
			ret_result_o <= ent_res[head];
		end
		// reads return the free count
		if (rd_acc)
			wb_dat_o <= dispatch_pkg::instr_word_t'(free_cnt);
	end

	// entry view for the dispatcher
	assign iss.ent_valid = ent_valid;
	assign iss.ent_out = ent_out;
	assign iss.ent_done = ent_done;
	assign iss.ent_pred = ent_pred;
	assign iss.ent_cls = ent_cls;
	assign iss.ent_opa = ent_opa;
	assign iss.ent_opb = ent_opb;
	assign iss.head = head;

endmodule

// ==== hw/dispatch_ifs.sv ====
`timescale 1ns/1ns

// issue lanes from dispatcher to units, plus the buffer's entry view
interface issue_if;

	// per-lane issue, registered in the dispatcher
	logic [dispatch_pkg::NUM_UNITS-1:0] valid;
	dispatch_pkg::buf_ndx_t ndx [dispatch_pkg::NUM_UNITS];
	dispatch_pkg::operand_t opa [dispatch_pkg::NUM_UNITS];
	dispatch_pkg::operand_t opb [dispatch_pkg::NUM_UNITS];
	// predicate false, unit must return zero
	logic [dispatch_pkg::NUM_UNITS-1:0] nop_sub;
	// unit cannot take a new issue this cycle
	logic [dispatch_pkg::NUM_UNITS-1:0] busy;

	// entry state as seen by the ready search
	logic [dispatch_pkg::DBF_ENTRIES-1:0] ent_valid;
	logic [dispatch_pkg::DBF_ENTRIES-1:0] ent_out;
	logic [dispatch_pkg::DBF_ENTRIES-1:0] ent_done;
	logic [dispatch_pkg::DBF_ENTRIES-1:0] ent_pred;
	dispatch_pkg::op_class_e ent_cls [dispatch_pkg::DBF_ENTRIES];
	dispatch_pkg::operand_t ent_opa [dispatch_pkg::DBF_ENTRIES];
	dispatch_pkg::operand_t ent_opb [dispatch_pkg::DBF_ENTRIES];
	// oldest entry, where the search starts
	dispatch_pkg::buf_ndx_t head;

	modport ctrl (
		output valid, ndx, opa, opb, nop_sub,
		input busy,
		input ent_valid, ent_out, ent_done, ent_pred, ent_cls, ent_opa, ent_opb, head
	);

	modport unit (
		input valid, ndx, opa, opb, nop_sub,
		output busy
	);

	// buffer watches issue to set its out flags
	modport mon (
		input valid, ndx,
		output ent_valid, ent_out, ent_done, ent_pred, ent_cls, ent_opa, ent_opb, head
	);

endinterface

// results from units back to the buffer, one lane per unit
interface writeback_if;

	logic [dispatch_pkg::NUM_UNITS-1:0] valid;
	dispatch_pkg::buf_ndx_t ndx [dispatch_pkg::NUM_UNITS];
	dispatch_pkg::result_t res [dispatch_pkg::NUM_UNITS];

	modport src (output valid, ndx, res);
	modport dst (input valid, ndx, res);

endinterface

// ==== hw/dispatch_pkg.sv ====
package dispatch_pkg;

	// ============================================================
	// sizes
	// ============================================================

	// dispatch buffer depth, pointers wrap on a power of two
	localparam int DBF_ENTRIES = 8;

	// lane n of issue and writeback belongs to unit n
	localparam int NUM_UNITS = 3;

	// cycles from issue to writeback per unit
	localparam int ALU_LATENCY = 1;
	localparam int MUL_LATENCY = 3;
	localparam int FLOW_LATENCY = 2;

	// ============================================================
	// types
	// ============================================================

	typedef logic [2:0] buf_ndx_t;
	// entry count, needs one more bit than the index for the full case
	typedef logic [3:0] buf_cnt_t;
	typedef logic [4:0] tag_t;
	typedef logic [11:0] operand_t;
	// wide enough for a full 12x12 product
	typedef logic [23:0] result_t;
	typedef logic [31:0] instr_word_t;

	// class encoding equals the unit number that executes it
	typedef enum logic [1:0] {
		CLS_ALU = 2'd0,
		CLS_MUL = 2'd1,
		CLS_FLOW = 2'd2,
		CLS_NOP = 2'd3
	} op_class_e;

	// ============================================================
	// instruction word fields
	// ============================================================

	localparam int CLS_HI = 31;
	localparam int CLS_LO = 30;
	localparam int PRED_BIT = 29;
	localparam int TAG_HI = 28;
	localparam int TAG_LO = 24;
	localparam int OPA_HI = 23;
	localparam int OPA_LO = 12;
	localparam int OPB_HI = 11;
	localparam int OPB_LO = 0;

endpackage

// ==== hw/dispatch_top.sv ====
`timescale 1ns/1ns

module dispatch_top (
	input logic clk,
	input logic rst,
	// host port, wishbone classic slave
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input dispatch_pkg::instr_word_t wb_dat_i,
	output dispatch_pkg::instr_word_t wb_dat_o,
	output logic wb_ack_o,
	// in-order retirement
	output logic ret_valid_o,
	output dispatch_pkg::tag_t ret_tag_o,
	output dispatch_pkg::result_t ret_result_o
);

	issue_if iss ();
	writeback_if wbk ();

	// ============================================================
	// buffer and control
	// ============================================================

	dispatch_buffer dispatch_buffer_i (
		.clk (clk),
		.rst (rst),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i (wb_we_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.ret_valid_o (ret_valid_o),
		.ret_tag_o (ret_tag_o),
		.ret_result_o (ret_result_o),
		.iss (iss.mon),
		.wb (wbk.dst)
	);

	instr_dispatcher instr_dispatcher_i (
		.clk (clk),
		.rst (rst),
		.iss (iss.ctrl)
	);

	// ============================================================
	// functional units
	// ============================================================

	exec_unit #(
		.LATENCY (dispatch_pkg::ALU_LATENCY),
		.UNIT_CLASS (dispatch_pkg::CLS_ALU)
	) alu_unit_i (
		.clk (clk),
		.rst (rst),
		.iss (iss.unit),
		.wb (wbk.src)
	);

	// pipelined, up to three in flight
	exec_unit #(
		.LATENCY (dispatch_pkg::MUL_LATENCY),
		.UNIT_CLASS (dispatch_pkg::CLS_MUL)
	) mul_unit_i (
		.clk (clk),
		.rst (rst),
		.iss (iss.unit),
		.wb (wbk.src)
	);

	exec_unit #(
		.LATENCY (dispatch_pkg::FLOW_LATENCY),
		.UNIT_CLASS (dispatch_pkg::CLS_FLOW)
	) flow_unit_i (
		.clk (clk),
		.rst (rst),
		.iss (iss.unit),
		.wb (wbk.src)
	);

endmodule

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit #(
	parameter int LATENCY = 1,
	parameter dispatch_pkg::op_class_e UNIT_CLASS = dispatch_pkg::CLS_ALU
) (
	input logic clk,
	input logic rst,
	issue_if.unit iss,
	writeback_if.src wb
);

	// lane number follows from the class encoding
	localparam int LANE = int'(UNIT_CLASS);

	// result formed at pipeline entry
	dispatch_pkg::result_t res_in;

	// ============================================================
	// shift pipeline
	// ============================================================

	logic [LATENCY-1:0] st_valid;
	dispatch_pkg::buf_ndx_t st_ndx [LATENCY];
	dispatch_pkg::result_t st_res [LATENCY];

	always_comb begin
		res_in = '0;
		case (UNIT_CLASS)
			dispatch_pkg::CLS_ALU:
				res_in = dispatch_pkg::result_t'(iss.opa[LANE])
					+ dispatch_pkg::result_t'(iss.opb[LANE]);
			dispatch_pkg::CLS_MUL:
				res_in = dispatch_pkg::result_t'(iss.opa[LANE])
					* dispatch_pkg::result_t'(iss.opb[LANE]);
			// unsigned compare
			dispatch_pkg::CLS_FLOW:
				res_in = (iss.opa[LANE] < iss.opb[LANE]) ? dispatch_pkg::result_t'(1) : '0;
			default:
				res_in = '0;
		endcase
		// predicated off
		if (iss.nop_sub[LANE])
			res_in = '0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			st_valid <= '0;
		end else begin
			st_valid[0] <= iss.valid[LANE];
			for (int s = LATENCY - 1; s > 0; s--) begin
				st_valid[s] <= st_valid[s-1];
			end
		end
	end

	// index and data ride alongside valid
	always_ff @(posedge clk) begin
		st_ndx[0] <= iss.ndx[LANE];
		st_res[0] <= res_in;
		for (int s = LATENCY - 1; s > 0; s--) begin
			st_ndx[s] <= st_ndx[s-1];
			st_res[s] <= st_res[s-1];
		end
	end

	// last stage is the writeback
	assign wb.valid[LANE] = st_valid[LATENCY-1];
	assign wb.ndx[LANE] = st_ndx[LATENCY-1];
	assign wb.res[LANE] = st_res[LATENCY-1];

	// takes a new item every cycle
	assign iss.busy[LANE] = 1'b0;

endmodule

// ==== hw/instr_dispatcher.sv ====
`timescale 1ns/1ns

module instr_dispatcher (
	input logic clk,
	input logic rst,
	issue_if.ctrl iss
);

	// per physical entry, ready for issue
	logic [dispatch_pkg::DBF_ENTRIES-1:0] elig;

	// combinational picks, one per lane
	logic [dispatch_pkg::NUM_UNITS-1:0] pick_v;
	dispatch_pkg::buf_ndx_t pick_ndx [dispatch_pkg::NUM_UNITS];

	// entry under inspection in the scan
	dispatch_pkg::buf_ndx_t scan;

	// out flag lags issue by a cycle, so last cycle's lanes must be skipped
	function automatic logic issued_last(input dispatch_pkg::buf_ndx_t idx);
		logic hit;
		hit = 1'b0;
		for (int u = 0; u < dispatch_pkg::NUM_UNITS; u++) begin
			if (iss.valid[u] && iss.ndx[u] == idx)
				hit = 1'b1;
		end
		return hit;
	endfunction

	// ============================================================
	// ready search
	// ============================================================

	always_comb begin
		for (int e = 0; e < dispatch_pkg::DBF_ENTRIES; e++) begin
			elig[e] = iss.ent_valid[e]
				&& !iss.ent_out[e]
				&& !iss.ent_done[e]
				&& iss.ent_cls[e] != dispatch_pkg::CLS_NOP
				&& !issued_last(dispatch_pkg::buf_ndx_t'(e));
		end
	end

	// walk from the head so each unit gets its oldest ready entry
	always_comb begin
		pick_v = '0;
		scan = iss.head;
		for (int u = 0; u < dispatch_pkg::NUM_UNITS; u++) begin
			pick_ndx[u] = '0;
		end
		for (int k = 0; k < dispatch_pkg::DBF_ENTRIES; k++) begin
			scan = iss.head + dispatch_pkg::buf_ndx_t'(k);
			for (int u = 0; u < dispatch_pkg::NUM_UNITS; u++) begin
				// class value doubles as the unit number
				if (elig[scan] && !iss.busy[u] && !pick_v[u]
					&& iss.ent_cls[scan] == dispatch_pkg::op_class_e'(u)) begin
					pick_v[u] = 1'b1;
					pick_ndx[u] = scan;
				end
			end
		end
	end

	// ============================================================
	// registered issue lanes
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst)
			iss.valid <= '0;
		else
			iss.valid <= pick_v;
	end

	// lane payload, only meaningful with valid
	always_ff @(posedge clk) begin
		for (int u = 0; u < dispatch_pkg::NUM_UNITS; u++) begin
			iss.ndx[u] <= pick_ndx[u];
			iss.opa[u] <= iss.ent_opa[pick_ndx[u]];
			iss.opb[u] <= iss.ent_opb[pick_ndx[u]];
			// predicate false still goes out, as a nop
			iss.nop_sub[u] <= !iss.ent_pred[pick_ndx[u]];
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_top -f verilog.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// ==== verif/tb_checker.sv ====
`timescale 1ns/1ns

// watches the host port and the retirement port of the DUT
module tb_checker (
	input logic clk,
	input logic rst,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input dispatch_pkg::instr_word_t dat_wr_i,
	input dispatch_pkg::instr_word_t dat_rd_i,
	input logic ack_i,
	input logic ret_valid_i,
	input dispatch_pkg::tag_t ret_tag_i,
	input dispatch_pkg::result_t ret_result_i,
	output int pending_o,
	output int value_errs_o,
	output int other_errs_o
);

	// accepted words in program order, waiting for retirement
	dispatch_pkg::instr_word_t words [$];

	// request seen on the bus but not acked yet
	logic req_seen;
	logic req_we;
	dispatch_pkg::instr_word_t req_dat;

	dispatch_pkg::instr_word_t cur;
	dispatch_pkg::instr_word_t exp_free;
	dispatch_pkg::result_t exp_res;
	dispatch_pkg::tag_t exp_tag;

	int value_errs;
	int other_errs;

	// ============================================================
	// reference model
	// ============================================================

	function automatic dispatch_pkg::result_t expected_result(input dispatch_pkg::instr_word_t w);
		logic [1:0] cls;
		logic pred;
		logic [11:0] a;
		logic [11:0] b;
		cls = w[dispatch_pkg::CLS_HI:dispatch_pkg::CLS_LO];
		pred = w[dispatch_pkg::PRED_BIT];
		a = w[dispatch_pkg::OPA_HI:dispatch_pkg::OPA_LO];
		b = w[dispatch_pkg::OPB_HI:dispatch_pkg::OPB_LO];
		// nops and predicated-off words give zero
		if (!pred || cls == dispatch_pkg::CLS_NOP)
			return '0;
		case (cls)
			dispatch_pkg::CLS_ALU: return dispatch_pkg::result_t'(a) + dispatch_pkg::result_t'(b);
			dispatch_pkg::CLS_MUL: return dispatch_pkg::result_t'(a) * dispatch_pkg::result_t'(b);
			// unsigned less-than
			default: return (a < b) ? dispatch_pkg::result_t'(1) : '0;
		endcase
	endfunction

	// ============================================================
	// compare process
	// ============================================================

	// sample on the falling edge, all DUT outputs are settled there
	always @(negedge clk) begin
		if (rst) begin
			words.delete();
			req_seen = 1'b0;
			value_errs = 0;
			other_errs = 0;
		end else begin
			if (ack_i) begin
				if (!req_seen) begin
					other_errs++;
					$display("ack at %0t without a pending request", $time);
				end else if (req_we) begin
					words.push_back(req_dat);
				end else begin
					// host reads only while the buffer sits idle
					exp_free = dispatch_pkg::instr_word_t'(dispatch_pkg::DBF_ENTRIES - words.size());
					if (dat_rd_i !== exp_free) begin
						value_errs++;
						$display("FAIL %0t wb_dat_o expected %0h got %0h", $time, exp_free, dat_rd_i);
					end
				end
				req_seen = 1'b0;
			end else if (cyc_i && stb_i) begin
				// held until ack, so the latest copy is the accepted one
				req_seen = 1'b1;
				req_we = we_i;
				req_dat = dat_wr_i;
			end
			if (ret_valid_i) begin
				if (words.size() == 0) begin
					other_errs++;
					$display("retirement at %0t with no word left to retire", $time);
				end else begin
					cur = words.pop_front();
					exp_tag = cur[dispatch_pkg::TAG_HI:dispatch_pkg::TAG_LO];
					exp_res = expected_result(cur);
					if (ret_tag_i !== exp_tag) begin
						value_errs++;
						$display("FAIL %0t ret_tag_o expected %0h got %0h", $time, exp_tag, ret_tag_i);
					end
					if (ret_result_i !== exp_res) begin
						value_errs++;
						$display("FAIL %0t ret_result_o expected %0h got %0h", $time, exp_res,
							ret_result_i);
					end
				end
			end
		end
		pending_o = words.size();
	end

	assign value_errs_o = value_errs;
	assign other_errs_o = other_errs;

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;

	localparam int ACK_TIMEOUT = 200;
	localparam int DRAIN_TIMEOUT = 2000;

	logic clk;
	logic rst;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	dispatch_pkg::instr_word_t wb_dat_i;
	dispatch_pkg::instr_word_t wb_dat_o;
	logic wb_ack_o;
	logic ret_valid_o;
	dispatch_pkg::tag_t ret_tag_o;
	dispatch_pkg::result_t ret_result_o;

	logic [15:0] lfsr_state;
	int timeout_errs;
	int pending;
	int value_errs;
	int other_errs;

	dispatch_top dispatch_top_i (
		.clk (clk),
		.rst (rst),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i (wb_we_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.ret_valid_o (ret_valid_o),
		.ret_tag_o (ret_tag_o),
		.ret_result_o (ret_result_o)
	);

	tb_checker tb_checker_i (
		.clk (clk),
		.rst (rst),
		.cyc_i (wb_cyc_i),
		.stb_i (wb_stb_i),
		.we_i (wb_we_i),
		.dat_wr_i (wb_dat_i),
		.dat_rd_i (wb_dat_o),
		.ack_i (wb_ack_o),
		.ret_valid_i (ret_valid_o),
		.ret_tag_i (ret_tag_o),
		.ret_result_i (ret_result_o),
		.pending_o (pending),
		.value_errs_o (value_errs),
		.other_errs_o (other_errs)
	);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ============================================================
	// stimulus helpers
	// ============================================================

	// galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic dispatch_pkg::instr_word_t make_word(input logic [1:0] cls,
		input logic pred);
		dispatch_pkg::instr_word_t w;
		w = '0;
		w[dispatch_pkg::CLS_HI:dispatch_pkg::CLS_LO] = cls;
		w[dispatch_pkg::PRED_BIT] = pred;
		w[dispatch_pkg::TAG_HI:dispatch_pkg::TAG_LO] = 5'(rand_bits(5));
		w[dispatch_pkg::OPA_HI:dispatch_pkg::OPA_LO] = 12'(rand_bits(12));
		w[dispatch_pkg::OPB_HI:dispatch_pkg::OPB_LO] = 12'(rand_bits(12));
		return w;
	endfunction

	// flow word with chosen operands for the compare edges
	function automatic dispatch_pkg::instr_word_t flow_word(input logic [11:0] a,
		input logic [11:0] b);
		dispatch_pkg::instr_word_t w;
		w = make_word(dispatch_pkg::CLS_FLOW, 1'b1);
		w[dispatch_pkg::OPA_HI:dispatch_pkg::OPA_LO] = a;
		w[dispatch_pkg::OPB_HI:dispatch_pkg::OPB_LO] = b;
		return w;
	endfunction

	// one classic cycle that starts and ends 1 ns after a rising edge
	task automatic host_access(input logic we, input dispatch_pkg::instr_word_t d);
		int waited;
		waited = 0;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_dat_i = d;
		@(posedge clk);
		#1;
		// a full buffer holds ack back
		while (!wb_ack_o && waited < ACK_TIMEOUT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!wb_ack_o) begin
			timeout_errs++;
			$display("no ack from the buffer within %0d cycles at %0t", ACK_TIMEOUT, $time);
		end
		// strobe drops in the ack cycle
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (pending != 0 && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (pending != 0) begin
			timeout_errs++;
			$display("buffer still holds %0d words after %0d cycles", pending, DRAIN_TIMEOUT);
		end
		@(posedge clk);
		#1;
	endtask

	// ============================================================
	// test sequence
	// ============================================================

	initial begin
		logic [1:0] cls;
		logic pred;
		int total_errs;
		rst = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_dat_i = '0;
		lfsr_state = 16'd12492;
		timeout_errs = 0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;
		// empty buffer reports all entries free
		host_access(1'b0, '0);
		// plain sums
		repeat (4) host_access(1'b1, make_word(dispatch_pkg::CLS_ALU, 1'b1));
		// products finish late but retire in order
		for (int i = 0; i < 6; i++) begin
			cls = (i % 2 == 0) ? dispatch_pkg::CLS_MUL : dispatch_pkg::CLS_ALU;
			host_access(1'b1, make_word(cls, 1'b1));
		end
		// random compares followed by below, above and equal
		repeat (3) host_access(1'b1, make_word(dispatch_pkg::CLS_FLOW, 1'b1));
		host_access(1'b1, flow_word(12'd5, 12'd9));
		host_access(1'b1, flow_word(12'hfff, 12'h001));
		host_access(1'b1, flow_word(12'h123, 12'h123));
		// predicated off in every class and then both kinds of nop
		for (int c = 0; c < 3; c++)
			host_access(1'b1, make_word(c[1:0], 1'b0));
		host_access(1'b1, make_word(dispatch_pkg::CLS_NOP, 1'b1));
		host_access(1'b1, make_word(dispatch_pkg::CLS_NOP, 1'b0));
		wait_drain();
		// ten back-to-back writes while older words keep retiring
		for (int i = 0; i < 10; i++) begin
			cls = 2'(rand_bits(2));
			pred = 1'(rand_bits(1));
			host_access(1'b1, make_word(cls, pred));
		end
		wait_drain();
		host_access(1'b0, '0);
		repeat (4) @(posedge clk);
		total_errs = value_errs + other_errs + timeout_errs;
		if (pending != 0) begin
			total_errs++;
			$display("%0d written words never retired", pending);
		end
		$display("errors: %0d value, %0d protocol, %0d timeout", value_errs, other_errs,
			timeout_errs);
		if (total_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
hw/dispatch_pkg.sv
hw/dispatch_ifs.sv
hw/exec_unit.sv
hw/dispatch_buffer.sv
hw/instr_dispatcher.sv
hw/dispatch_top.sv
verif/tb_checker.sv
verif/tb_top.sv
